/* filelist.f */
+incdir+verilog
verilog/video_crop_pkg.sv
verilog/crop_config_regs.sv
verilog/frame_sync_gate.sv
verilog/axis_window.sv
verilog/axis_skid_buffer.sv
verilog/video_crop_top.sv
tests/video_crop_tb.sv

/* tests/video_crop_tb.sv */
`default_nettype none

`include "video_crop_params.svh"

module video_crop_tb import video_crop_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS     = 7;
	localparam int BEAT_TIMEOUT  = 200;
	localparam int DRAIN_TIMEOUT = 4000;

	typedef struct packed {
		logic                    user;
		logic                    last;
		logic [`PIXEL_WIDTH-1:0] data;
	} beat_t;

	typedef struct packed {
		int img_w;
		int img_h;
		int left;
		int top;
		int width;
		int height;
		int junk;
		int gaps;
		int bp;
	} test_t;

	// Image w, h | window left, top, w, h | junk beats | input gaps | back-pressure
	test_t tests [NUM_TESTS] = '{
		'{ 8,  6,  0,  0,  8,  6, 5, 0, 0},
		'{ 8,  6,  2,  1,  4,  3, 0, 0, 0},
		'{16,  8,  3,  2,  9,  5, 0, 1, 1},
		'{12, 10,  0,  4, 12,  2, 0, 0, 1},
		'{10,  7,  5,  3,  1,  4, 3, 1, 1},
		'{20, 12, 19, 11,  1,  1, 0, 1, 0},
		'{24, 16,  1,  1, 22, 14, 0, 1, 1}
	};

	////////////////////
	// DUT and clock
	////////////////////

	logic                    clk = 1'b0;
	logic                    resetn;
	logic                    cfg_we;
	crop_reg_t               cfg_sel;
	logic [`IMG_WBITS-1:0]   cfg_wdata;
	logic                    s_tvalid;
	logic [`PIXEL_WIDTH-1:0] s_tdata;
	logic                    s_tuser;
	logic                    s_tlast;
	logic                    s_tready;
	logic                    m_tvalid;
	logic [`PIXEL_WIDTH-1:0] m_tdata;
	logic                    m_tuser;
	logic                    m_tlast;
	logic                    m_tready;

	always #4 clk = ~clk;

	video_crop_top i_dut (
		.clk       (clk),
		.resetn    (resetn),
		.cfg_we    (cfg_we),
		.cfg_sel   (cfg_sel),
		.cfg_wdata (cfg_wdata),
		.s_tvalid  (s_tvalid),
		.s_tdata   (s_tdata),
		.s_tuser   (s_tuser),
		.s_tlast   (s_tlast),
		.s_tready  (s_tready),
		.m_tvalid  (m_tvalid),
		.m_tdata   (m_tdata),
		.m_tuser   (m_tuser),
		.m_tlast   (m_tlast),
		.m_tready  (m_tready)
	);

	beat_t       exp_q [$];
	beat_t       exp_beat;
	int          seed = 32'hb1cc3b1e;
	logic [31:0] rnd;
	logic        ready_draw;
	logic        gap_draw;
	logic        hold_ready;
	logic        bp_on;
	logic        sof_sent;
	logic        junk_phase;
	int          error_count;
	int          beat_count;

	////////////////////
	// Helpers
	////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, what, actual,
				expected);
			error_count++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [`PIXEL_WIDTH-1:0] pixel_value(input int row, input int col);
		return (row * 16 + col) % 256;
	endfunction

	task automatic apply_reset();
		resetn = 1'b0;
		repeat (3) step();
		resetn = 1'b1;
		// No edge out of reset yet, outputs show their reset values
		@(negedge clk);
		check_value(m_tvalid, 1'b0, "m_tvalid after reset");
		check_value(s_tready, 1'b1, "s_tready after reset");
		step();
	endtask

	task automatic write_reg(input crop_reg_t sel, input int value);
		cfg_we    = 1'b1;
		cfg_sel   = sel;
		cfg_wdata = value[`IMG_WBITS-1:0];
		step();
		cfg_we    = 1'b0;
	endtask

	task automatic write_window(input test_t t);
		write_reg(CROP_LEFT, t.left);
		write_reg(CROP_TOP, t.top);
		write_reg(CROP_WIDTH, t.width);
		write_reg(CROP_HEIGHT, t.height);
	endtask

	// Starts and ends just after a rising edge
	task automatic send_beat(input logic [`PIXEL_WIDTH-1:0] data, input logic user,
			input logic last, input int gaps);
		int   idle;
		int   tries;
		logic taken;
		idle = 0;
		while (gaps != 0 && gap_draw && idle < 4) begin
			s_tvalid = 1'b0;
			step();
			idle++;
		end
		s_tvalid = 1'b1;
		s_tdata  = data;
		s_tuser  = user;
		s_tlast  = last;
		tries    = 0;
		taken    = 1'b0;
		while (!taken && tries < BEAT_TIMEOUT) begin
			@(negedge clk);
			taken = s_tready;
			if (taken && user) begin
				sof_sent = 1'b1;
			end
			step();
			tries++;
		end
		s_tvalid = 1'b0;
		if (!taken) begin
			$display("Input beat %0h was not accepted within %0d cycles", data, BEAT_TIMEOUT);
			error_count++;
		end
	endtask

	task automatic send_frame(input test_t t);
		for (int r = 0; r < t.img_h; r++) begin
			for (int c = 0; c < t.img_w; c++) begin
				send_beat(pixel_value(r, c), (r == 0 && c == 0), (c == t.img_w - 1), t.gaps);
			end
		end
	endtask

	// Reference crop of one frame in raster order
	task automatic push_expected(input test_t t);
		beat_t b;
		for (int r = t.top; r < t.top + t.height; r++) begin
			for (int c = t.left; c < t.left + t.width; c++) begin
				b.data = pixel_value(r, c);
				b.user = (r == t.top && c == t.left);
				b.last = (c == t.left + t.width - 1);
				exp_q.push_back(b);
			end
		end
	endtask

	task automatic wait_frame_start();
		int n;
		n = 0;
		while (!sof_sent && n < BEAT_TIMEOUT) begin
			step();
			n++;
		end
		if (!sof_sent) begin
			$display("Start-of-frame beat was not accepted within %0d cycles", BEAT_TIMEOUT);
			error_count++;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
			step();
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Output stalled with %0d expected beats never seen", exp_q.size());
			error_count++;
			exp_q.delete();
		end
		// Quiet period to catch stray or repeated beats
		repeat (10) step();
	endtask

	////////////////////
	// Ready and collector
	////////////////////

	// New draws each falling edge
	always @(negedge clk) begin
		rnd        = $random(seed);
		ready_draw = (rnd[1:0] != 2'b00);
		gap_draw   = (rnd[3:2] == 2'b00);
	end

	always @(posedge clk) begin
		hold_ready = bp_on && !ready_draw;
		#1;
		m_tready = !hold_ready;
	end

	// Handshake is stable at the falling edge
	always @(negedge clk) begin
		if (resetn && m_tvalid && m_tready) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected output beat at %0d ns with data %0h", $time, m_tdata);
				error_count++;
			end else begin
				exp_beat = exp_q.pop_front();
				check_value(m_tdata, exp_beat.data, "tdata");
				check_value(m_tuser, exp_beat.user, "tuser");
				check_value(m_tlast, exp_beat.last, "tlast");
			end
			beat_count++;
		end
	end

	// Window is still zero here, so junk is only visible on the link into it
	always @(negedge clk) begin
		if (junk_phase && i_dut.a_tvalid) begin
			$display("Junk beat %0h reached the window stage at %0d ns", i_dut.a_tdata, $time);
			error_count++;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		test_t t;
		test_t nxt;
		int    start_err;
		int    start_beats;
		int    failed;
		resetn      = 1'b0;
		cfg_we      = 1'b0;
		cfg_sel     = CROP_LEFT;
		cfg_wdata   = '0;
		s_tvalid    = 1'b0;
		s_tdata     = '0;
		s_tuser     = 1'b0;
		s_tlast     = 1'b0;
		m_tready    = 1'b1;
		bp_on       = 1'b0;
		ready_draw  = 1'b1;
		gap_draw    = 1'b0;
		sof_sent    = 1'b0;
		junk_phase  = 1'b0;
		error_count = 0;
		beat_count  = 0;
		failed      = 0;
		step();
		for (int i = 0; i < NUM_TESTS; i++) begin
			t           = tests[i];
			start_err   = error_count;
			start_beats = beat_count;
			if (t.junk != 0) begin
				// Reset returns the synchronizer to seek
				apply_reset();
				// Window written while the stream is idle
				write_window(t);
				junk_phase = 1'b1;
				for (int j = 0; j < t.junk; j++) begin
					send_beat(8'hf0 + j, 1'b0, (j % 4 == 3), t.gaps);
				end
				junk_phase = 1'b0;
			end
			bp_on = (t.bp != 0);
			push_expected(t);
			push_expected(t);
			send_frame(t);
			sof_sent = 1'b0;
			if (i + 1 < NUM_TESTS && tests[i + 1].junk == 0) begin
				nxt = tests[i + 1];
				// Next window goes to the shadow while the second frame runs
				fork
					send_frame(t);
					begin
						wait_frame_start();
						write_window(nxt);
					end
				join
			end else begin
				send_frame(t);
			end
			wait_drain();
			bp_on = 1'b0;
			check_value(beat_count - start_beats, 2 * t.width * t.height, "beats in test");
			if (error_count != start_err) begin
				failed++;
			end
			$display("Test %0d: image %0dx%0d, window %0dx%0d at (%0d,%0d), %0d beats, %s",
				i, t.img_w, t.img_h, t.width, t.height, t.left, t.top,
				beat_count - start_beats, (error_count == start_err) ? "pass" : "fail");
		end
		$display("Summary: %0d tests, %0d failed, %0d beats checked, %0d errors",
			NUM_TESTS, failed, beat_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/axis_skid_buffer.sv */
`default_nettype none

`include "video_crop_params.svh"

module axis_skid_buffer (
	input  wire                     clk,
	input  wire                     resetn,

	// Upstream side
	input  wire                     s_tvalid,
	input  wire [`PIXEL_WIDTH-1:0]  s_tdata,
	input  wire                     s_tuser,
	input  wire                     s_tlast,
	output logic                    s_tready,

	// Downstream side
	output logic                    m_tvalid,
	output logic [`PIXEL_WIDTH-1:0] m_tdata,
	output logic                    m_tuser,
	output logic                    m_tlast,
	input  wire                     m_tready
);

	// tuser, tlast and pixel packed as one word
	localparam int WORD_W = `PIXEL_WIDTH + 2;

	logic [WORD_W-1:0] s_word;
	logic [WORD_W-1:0] main_word;
	logic [WORD_W-1:0] skid_word;
	logic              skid_valid;
	logic              s_fire;
	logic              main_free;

	assign s_word = {s_tuser, s_tlast, s_tdata};
	assign s_fire = s_tvalid && s_tready;

	// Main entry empties or drains this cycle
	assign main_free = !m_tvalid || m_tready;

	assign {m_tuser, m_tlast, m_tdata} = main_word;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_tvalid   <= 1'b0;
			skid_valid <= 1'b0;
			s_tready   <= 1'b1;
		end else if (main_free) begin
			// Skid entry refills main first, ready was low meanwhile
			m_tvalid   <= skid_valid || s_fire;
			skid_valid <= 1'b0;
			s_tready   <= 1'b1;
		end else if (s_fire) begin
			// Main is stuck, park the beat and stop upstream
			skid_valid <= 1'b1;
			s_tready   <= 1'b0;
		end
	end

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (main_free) begin
			main_word <= skid_valid ? skid_word : s_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!main_free && s_fire) begin
			skid_word <= s_word;
		end
	end

endmodule

`default_nettype wire

/* verilog/axis_window.sv */
`default_nettype none

`include "video_crop_params.svh"

module axis_window (
	input  wire                     clk,
	input  wire                     resetn,

	// Active window
	input  wire [`IMG_WBITS-1:0]    win_left,
	input  wire [`IMG_HBITS-1:0]    win_top,
	input  wire [`IMG_WBITS-1:0]    win_width,
	input  wire [`IMG_HBITS-1:0]    win_height,

	// Full image in
	input  wire                     s_axis_tvalid,
	input  wire [`PIXEL_WIDTH-1:0]  s_axis_tdata,
	input  wire                     s_axis_tuser,
	input  wire                     s_axis_tlast,
	output logic                    s_axis_tready,

	// Cropped image out
	output logic                    m_axis_tvalid,
	output logic [`PIXEL_WIDTH-1:0] m_axis_tdata,
	output logic                    m_axis_tuser,
	output logic                    m_axis_tlast,
	input  wire                     m_axis_tready
);

	logic                  s_fire;
	logic                  dvalid;
	logic                  dlast;
	logic [`IMG_WBITS-1:0] col_idx;
	logic [`IMG_HBITS-1:0] row_idx;
	logic [`IMG_WBITS:0]   col_end;
	logic [`IMG_HBITS:0]   row_end;
	logic                  col_in;
	logic                  row_in;

	// Stage advances whenever nothing visible is stuck at the output
	assign s_axis_tready = !m_axis_tvalid || m_axis_tready;
	assign s_fire        = s_axis_tvalid && s_axis_tready;

	////////////////////
	// Position tracking
	////////////////////

	// Counters describe the pixel held in the output register
	always_ff @(posedge clk) begin
		if (!resetn) begin
			col_idx <= '0;
			row_idx <= '0;
			dlast   <= 1'b0;
		end else if (s_fire) begin
			dlast <= s_axis_tlast;
			if (s_axis_tuser) begin
				col_idx <= '0;
				row_idx <= '0;
			end else if (dlast) begin
				// Previous beat closed a line
				col_idx <= '0;
				row_idx <= row_idx + 1'b1;
			end else begin
				col_idx <= col_idx + 1'b1;
			end
		end
	end

	////////////////////
	// Pixel register
	////////////////////

	always_ff @(posedge clk) begin
		if (s_fire) begin
			m_axis_tdata <= s_axis_tdata;
		end
	end

	// Takes the input valid each time the stage may advance
	always_ff @(posedge clk) begin
		if (!resetn) begin
			dvalid <= 1'b0;
		end else if (s_axis_tready) begin
			dvalid <= s_axis_tvalid;
		end
	end

	////////////////////
	// Window compare
	////////////////////

	// One extra bit so left plus width does not wrap
	assign col_end = {1'b0, win_left} + {1'b0, win_width};
	assign row_end = {1'b0, win_top} + {1'b0, win_height};

	assign col_in = (col_idx >= win_left) && ({1'b0, col_idx} < col_end);
	assign row_in = (row_idx >= win_top) && ({1'b0, row_idx} < row_end);

	// Out-of-window pixels never show valid and get overwritten
	assign m_axis_tvalid = dvalid && col_in && row_in;

	// Markers are rebuilt for the cropped image
	assign m_axis_tlast = ({1'b0, col_idx} == col_end - 1'b1);
	assign m_axis_tuser = (col_idx == win_left) && (row_idx == win_top);

endmodule

`default_nettype wire

/* verilog/crop_config_regs.sv */
`default_nettype none

`include "video_crop_params.svh"

module crop_config_regs import video_crop_pkg::*; (
	input  wire                    clk,
	input  wire                    resetn,

	// Write port
	input  wire                    cfg_we,
	input  wire crop_reg_t         cfg_sel,
	input  wire [`IMG_WBITS-1:0]   cfg_wdata,

	// Accepted start-of-frame
	input  wire                    frame_start,

	// Active window
	output logic [`IMG_WBITS-1:0]  win_left,
	output logic [`IMG_HBITS-1:0]  win_top,
	output logic [`IMG_WBITS-1:0]  win_width,
	output logic [`IMG_HBITS-1:0]  win_height
);

	////////////////////
	// Shadow registers
	////////////////////

	logic [`IMG_WBITS-1:0] sh_left;
	logic [`IMG_HBITS-1:0] sh_top;
	logic [`IMG_WBITS-1:0] sh_width;
	logic [`IMG_HBITS-1:0] sh_height;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			sh_left   <= '0;
			sh_top    <= '0;
			sh_width  <= '0;
			sh_height <= '0;
		end else if (cfg_we) begin
			case (cfg_sel)
				CROP_LEFT:   sh_left   <= cfg_wdata;
				CROP_TOP:    sh_top    <= cfg_wdata[`IMG_HBITS-1:0];
				CROP_WIDTH:  sh_width  <= cfg_wdata;
				CROP_HEIGHT: sh_height <= cfg_wdata[`IMG_HBITS-1:0];
			endcase
		end
	end

	////////////////////
	// Active registers
	////////////////////

	// Load only at frame start so one frame sees one window.
	// A write in the same cycle lands in the shadow and waits a frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			win_left   <= '0;
			win_top    <= '0;
			win_width  <= '0;
			win_height <= '0;
		end else if (frame_start) begin
			win_left   <= sh_left;
			win_top    <= sh_top;
			win_width  <= sh_width;
			win_height <= sh_height;
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_sync_gate.sv */
`default_nettype none

`include "video_crop_params.svh"

module frame_sync_gate import video_crop_pkg::*; (
	input  wire                     clk,
	input  wire                     resetn,

	// Raw input stream
	input  wire                     s_tvalid,
	input  wire [`PIXEL_WIDTH-1:0]  s_tdata,
	input  wire                     s_tuser,
	input  wire                     s_tlast,
	output logic                    s_tready,

	// Stream toward the window stage
	output logic                    m_tvalid,
	output logic [`PIXEL_WIDTH-1:0] m_tdata,
	output logic                    m_tuser,
	output logic                    m_tlast,
	input  wire                     m_tready,

	// One cycle per accepted start-of-frame beat
	output logic                    frame_start
);

	sync_state_t state;
	sync_state_t state_next;
	logic        fwd;

	////////////////////
	// Forward decision
	////////////////////

	always_comb begin
		case (state)
			SYNC_SEEK: begin
				// Only a start-of-frame beat gets through
				fwd = s_tuser;
			end
			default: begin
				fwd = 1'b1;
			end
		endcase
	end

	// Dropped beats are swallowed with ready held high
	assign s_tready = fwd ? m_tready : 1'b1;
	assign m_tvalid = s_tvalid && fwd;

	// Payload is never touched, only valid and ready are gated
	assign m_tdata = s_tdata;
	assign m_tuser = s_tuser;
	assign m_tlast = s_tlast;

	assign frame_start = s_tvalid && s_tready && s_tuser;

	////////////////////
	// State register
	////////////////////

	always_comb begin
		state_next = state;
		if (state == SYNC_SEEK && frame_start) begin
			state_next = SYNC_PASS;
		end
	end

	// No way back to seek short of a reset
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= SYNC_SEEK;
		end else begin
			state <= state_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/video_crop_params.svh */
`ifndef VIDEO_CROP_PARAMS_SVH
`define VIDEO_CROP_PARAMS_SVH

////////////////////
// Pixel format
////////////////////

// One component per pixel
`define PIXEL_WIDTH 8

////////////////////
// Image geometry
////////////////////

// Column counter, window left and width
`define IMG_WBITS 12

// Row counter, window top and height
`define IMG_HBITS 12

`endif

/* verilog/video_crop_pkg.sv */
`default_nettype none

package video_crop_pkg;

	////////////////////
	// Configuration
	////////////////////

	// Register select on the write port
	typedef enum logic [1:0] {
		CROP_LEFT   = 2'd0,
		CROP_TOP    = 2'd1,
		CROP_WIDTH  = 2'd2,
		CROP_HEIGHT = 2'd3
	} crop_reg_t;

	////////////////////
	// Frame sync
	////////////////////

	// Seek drops beats until a start-of-frame, pass forwards everything
	typedef enum logic [0:0] {
		SYNC_SEEK = 1'b0,
		SYNC_PASS = 1'b1
	} sync_state_t;

endpackage

`default_nettype wire

/* verilog/video_crop_top.sv */
`default_nettype none

`include "video_crop_params.svh"

module video_crop_top import video_crop_pkg::*; (
	input  wire                     clk,
	input  wire                     resetn,

	// Window configuration
	input  wire                     cfg_we,
	input  wire crop_reg_t          cfg_sel,
	input  wire [`IMG_WBITS-1:0]    cfg_wdata,

	// Pixel stream in
	input  wire                     s_tvalid,
	input  wire [`PIXEL_WIDTH-1:0]  s_tdata,
	input  wire                     s_tuser,
	input  wire                     s_tlast,
	output logic                    s_tready,

	// Cropped stream out
	output logic                    m_tvalid,
	output logic [`PIXEL_WIDTH-1:0] m_tdata,
	output logic                    m_tuser,
	output logic                    m_tlast,
	input  wire                     m_tready
);

	logic                    frame_start;
	logic [`IMG_WBITS-1:0]   win_left;
	logic [`IMG_HBITS-1:0]   win_top;
	logic [`IMG_WBITS-1:0]   win_width;
	logic [`IMG_HBITS-1:0]   win_height;

	// Link a, synchronizer to window
	logic                    a_tvalid;
	logic [`PIXEL_WIDTH-1:0] a_tdata;
	logic                    a_tuser;
	logic                    a_tlast;
	logic                    a_tready;

	// Link b, window to skid buffer
	logic                    b_tvalid;
	logic [`PIXEL_WIDTH-1:0] b_tdata;
	logic                    b_tuser;
	logic                    b_tlast;
	logic                    b_tready;

	crop_config_regs i_cfg (
		.clk         (clk),
		.resetn      (resetn),
		.cfg_we      (cfg_we),
		.cfg_sel     (cfg_sel),
		.cfg_wdata   (cfg_wdata),
		.frame_start (frame_start),
		.win_left    (win_left),
		.win_top     (win_top),
		.win_width   (win_width),
		.win_height  (win_height)
	);

	frame_sync_gate i_sync (
		.clk         (clk),
		.resetn      (resetn),
		.s_tvalid    (s_tvalid),
		.s_tdata     (s_tdata),
		.s_tuser     (s_tuser),
		.s_tlast     (s_tlast),
		.s_tready    (s_tready),
		.m_tvalid    (a_tvalid),
		.m_tdata     (a_tdata),
		.m_tuser     (a_tuser),
		.m_tlast     (a_tlast),
		.m_tready    (a_tready),
		.frame_start (frame_start)
	);

	axis_window i_window (
		.clk           (clk),
		.resetn        (resetn),
		.win_left      (win_left),
		.win_top       (win_top),
		.win_width     (win_width),
		.win_height    (win_height),
		.s_axis_tvalid (a_tvalid),
		.s_axis_tdata  (a_tdata),
		.s_axis_tuser  (a_tuser),
		.s_axis_tlast  (a_tlast),
		.s_axis_tready (a_tready),
		.m_axis_tvalid (b_tvalid),
		.m_axis_tdata  (b_tdata),
		.m_axis_tuser  (b_tuser),
		.m_axis_tlast  (b_tlast),
		.m_axis_tready (b_tready)
	);

	axis_skid_buffer i_skid (
		.clk      (clk),
		.resetn   (resetn),
		.s_tvalid (b_tvalid),
		.s_tdata  (b_tdata),
		.s_tuser  (b_tuser),
		.s_tlast  (b_tlast),
		.s_tready (b_tready),
		.m_tvalid (m_tvalid),
		.m_tdata  (m_tdata),
		.m_tuser  (m_tuser),
		.m_tlast  (m_tlast),
		.m_tready (m_tready)
	);

endmodule

`default_nettype wire
